// File: l2_cache_geom_pkg.sv
package l2_cache_geom_pkg;

    // Address split: tag | index | byte offset.
    localparam int ADDR_W   = 16;
    localparam int OFFSET_W = 3;  // 8-byte lines.
    localparam int INDEX_W  = 3;  // 8 sets.
    localparam int TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;

    // Way number. The LRU bit of a set holds the way to evict next.
    typedef logic [0:0] way_t;

    // Source of the memory-side address.
    typedef logic [1:0] addr_sel_t;

    localparam addr_sel_t ADDR_SEL_REQ  = 2'b00;  // Request line address.
    localparam addr_sel_t ADDR_SEL_WAY0 = 2'b01;  // Way 0 victim.
    localparam addr_sel_t ADDR_SEL_WAY1 = 2'b10;  // Way 1 victim.

endpackage : l2_cache_geom_pkg

// File: l2_mem_pkg.sv
package l2_mem_pkg;

    localparam int LINE_W = 64;

    // Line address is tag and index together, offset dropped.
    localparam int LINE_ADDR_W = l2_cache_geom_pkg::TAG_W + l2_cache_geom_pkg::INDEX_W;

    typedef logic [LINE_W-1:0]      line_t;
    typedef logic [LINE_ADDR_W-1:0] line_addr_t;

endpackage : l2_mem_pkg

// File: l2_cache_control.sv
`timescale 1ns/10ps

module l2_cache_control (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          mem_read,
    input  logic                          mem_write,
    input  logic                          hit0,
    input  logic                          hit1,
    input  logic                          dirty0,
    input  logic                          dirty1,
    input  l2_cache_geom_pkg::way_t       lru,
    input  logic                          pmem_resp,
    output logic                          mem_resp,
    output logic                          pmem_read,
    output logic                          pmem_write,
    output logic                          load_lru,
    output logic                          lru_set,
    output logic                          load_tag0,
    output logic                          load_tag1,
    output logic                          load_valid0,
    output logic                          load_valid1,
    output logic                          valid_set0,
    output logic                          valid_set1,
    output logic                          load_dirty0,
    output logic                          load_dirty1,
    output logic                          dirty_set0,
    output logic                          dirty_set1,
    output l2_cache_geom_pkg::way_t       wdata_sel,
    output l2_cache_geom_pkg::addr_sel_t  addr_sel
);
    import l2_cache_geom_pkg::*;

    typedef enum logic [1:0] {
        process_request,
        write_back,
        fetch_line
    } state_t;

    state_t state, next_state;
    logic   req;
    logic   victim_dirty;

    assign req          = mem_read ^ mem_write;
    assign victim_dirty = (lru == '0) ? dirty0 : dirty1;

    always_comb begin
        mem_resp    = 1'b0;
        pmem_read   = 1'b0;
        pmem_write  = 1'b0;
        load_lru    = 1'b0;
        lru_set     = 1'b0;
        load_tag0   = 1'b0;
        load_tag1   = 1'b0;
        load_valid0 = 1'b0;
        load_valid1 = 1'b0;
        valid_set0  = 1'b0;
        valid_set1  = 1'b0;
        load_dirty0 = 1'b0;
        load_dirty1 = 1'b0;
        dirty_set0  = 1'b0;
        dirty_set1  = 1'b0;
        wdata_sel   = '0;
        addr_sel    = ADDR_SEL_REQ;
        case (state)
            process_request: begin
                if (req && hit0) begin
                    mem_resp = 1'b1;
                    load_lru = 1'b1;
                    lru_set  = 1'b1;  // Way 1 is evicted next.
                    if (mem_write) begin
                        load_tag0   = 1'b1;
                        load_dirty0 = 1'b1;
                        dirty_set0  = 1'b1;
                    end
                end else if (req && hit1) begin
                    mem_resp = 1'b1;
                    load_lru = 1'b1;  // lru_set low, way 0 is evicted next.
                    if (mem_write) begin
                        load_tag1   = 1'b1;
                        load_dirty1 = 1'b1;
                        dirty_set1  = 1'b1;
                    end
                end
            end
            write_back: begin
                pmem_write = 1'b1;
                wdata_sel  = lru;
                addr_sel   = (lru == '0) ? ADDR_SEL_WAY0 : ADDR_SEL_WAY1;
            end
            fetch_line: begin
                pmem_read = 1'b1;
                // Fill lands on the response edge; dirty is cleared with it.
                if (pmem_resp) begin
                    if (lru == '0) begin
                        load_tag0   = 1'b1;
                        load_valid0 = 1'b1;
                        valid_set0  = 1'b1;
                        load_dirty0 = 1'b1;
                    end else begin
                        load_tag1   = 1'b1;
                        load_valid1 = 1'b1;
                        valid_set1  = 1'b1;
                        load_dirty1 = 1'b1;
                    end
                end
            end
            default: ;
        endcase
    end

    always_comb begin
        next_state = state;
        case (state)
            process_request: begin
                if (req && !(hit0 || hit1)) begin
                    next_state = victim_dirty ? write_back : fetch_line;
                end
            end
            write_back: if (pmem_resp) next_state = fetch_line;
            fetch_line: if (pmem_resp) next_state = process_request;
            default:    next_state = process_request;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= process_request;
        end else begin
            state <= next_state;
        end
    end

endmodule : l2_cache_control

// File: l2_cache_datapath.sv
`timescale 1ns/10ps

module l2_cache_datapath (
    input  logic                          clk,
    input  logic                          arst_n,
    input  l2_cache_geom_pkg::addr_t      mem_address,
    input  l2_mem_pkg::line_t             mem_wdata,
    input  l2_mem_pkg::line_t             pmem_rdata,
    input  logic                          pmem_read,
    input  logic                          load_lru,
    input  logic                          lru_set,
    input  logic                          load_tag0,
    input  logic                          load_tag1,
    input  logic                          load_valid0,
    input  logic                          load_valid1,
    input  logic                          valid_set0,
    input  logic                          valid_set1,
    input  logic                          load_dirty0,
    input  logic                          load_dirty1,
    input  logic                          dirty_set0,
    input  logic                          dirty_set1,
    input  l2_cache_geom_pkg::way_t       wdata_sel,
    input  l2_cache_geom_pkg::addr_sel_t  addr_sel,
    output logic                          hit0,
    output logic                          hit1,
    output logic                          dirty0,
    output logic                          dirty1,
    output l2_cache_geom_pkg::way_t       lru,
    output l2_mem_pkg::line_t             mem_rdata,
    output l2_mem_pkg::line_addr_t        pmem_address,
    output l2_mem_pkg::line_t             pmem_wdata
);
    import l2_cache_geom_pkg::*;
    import l2_mem_pkg::*;

    localparam int WAYS = 2;
    localparam int SETS = 2 ** INDEX_W;

    tag_t                     tag_q  [WAYS][SETS];
    line_t                    data_q [WAYS][SETS];
    logic [WAYS-1:0][SETS-1:0] valid_q;
    logic [WAYS-1:0][SETS-1:0] dirty_q;
    way_t [SETS-1:0]          lru_q;

    tag_t       req_tag;
    index_t     index;
    line_t      line_in;
    logic [WAYS-1:0] hit_w;
    line_addr_t victim_addr [WAYS];

    // Strobes gathered per way.
    logic [WAYS-1:0] load_tag_w;
    logic [WAYS-1:0] load_valid_w;
    logic [WAYS-1:0] valid_set_w;
    logic [WAYS-1:0] load_dirty_w;
    logic [WAYS-1:0] dirty_set_w;

    assign load_tag_w   = {load_tag1, load_tag0};
    assign load_valid_w = {load_valid1, load_valid0};
    assign valid_set_w  = {valid_set1, valid_set0};
    assign load_dirty_w = {load_dirty1, load_dirty0};
    assign dirty_set_w  = {dirty_set1, dirty_set0};

    assign req_tag = mem_address[ADDR_W-1 -: TAG_W];
    assign index   = mem_address[OFFSET_W +: INDEX_W];

    // A fill is under way exactly while the line is being read from memory.
    assign line_in = pmem_read ? pmem_rdata : mem_wdata;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_w[w]       = valid_q[w][index] && (tag_q[w][index] == req_tag);
            victim_addr[w] = {tag_q[w][index], index};
        end
    end

    assign hit0   = hit_w[0];
    assign hit1   = hit_w[1];
    assign dirty0 = dirty_q[0][index];
    assign dirty1 = dirty_q[1][index];
    assign lru    = lru_q[index];

    assign mem_rdata  = hit_w[1] ? data_q[1][index] : data_q[0][index];
    assign pmem_wdata = data_q[wdata_sel][index];

    always_comb begin
        case (addr_sel)
            ADDR_SEL_WAY0: pmem_address = victim_addr[0];
            ADDR_SEL_WAY1: pmem_address = victim_addr[1];
            default:       pmem_address = {req_tag, index};
        endcase
    end

    // Tag and data storage.
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (load_tag_w[w]) begin
                tag_q[w][index]  <= req_tag;
                data_q[w][index] <= line_in;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (load_valid_w[w]) valid_q[w][index] <= valid_set_w[w];
                if (load_dirty_w[w]) dirty_q[w][index] <= dirty_set_w[w];
            end
            if (load_lru) begin
                lru_q[index] <= way_t'(lru_set);  // Points at the way not just used.
            end
        end
    end

endmodule : l2_cache_datapath

// File: l2_cache.sv
`timescale 1ns/10ps

module l2_cache (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  l2_cache_geom_pkg::addr_t  mem_address,
    input  l2_mem_pkg::line_t         mem_wdata,
    output logic                      mem_resp,
    output l2_mem_pkg::line_t         mem_rdata,
    input  logic                      pmem_resp,
    input  l2_mem_pkg::line_t         pmem_rdata,
    output logic                      pmem_read,
    output logic                      pmem_write,
    output l2_mem_pkg::line_addr_t    pmem_address,
    output l2_mem_pkg::line_t         pmem_wdata
);
    import l2_cache_geom_pkg::*;

    logic      hit0, hit1, dirty0, dirty1;
    way_t      lru;
    logic      load_lru, lru_set;
    logic      load_tag0, load_tag1;
    logic      load_valid0, load_valid1, valid_set0, valid_set1;
    logic      load_dirty0, load_dirty1, dirty_set0, dirty_set1;
    way_t      wdata_sel;
    addr_sel_t addr_sel;

    l2_cache_control control_i (
        .clk, .arst_n,
        .mem_read, .mem_write,
        .hit0, .hit1, .dirty0, .dirty1, .lru,
        .pmem_resp,
        .mem_resp, .pmem_read, .pmem_write,
        .load_lru, .lru_set,
        .load_tag0, .load_tag1,
        .load_valid0, .load_valid1, .valid_set0, .valid_set1,
        .load_dirty0, .load_dirty1, .dirty_set0, .dirty_set1,
        .wdata_sel, .addr_sel
    );

    l2_cache_datapath datapath_i (
        .clk, .arst_n,
        .mem_address, .mem_wdata, .pmem_rdata, .pmem_read,
        .load_lru, .lru_set,
        .load_tag0, .load_tag1,
        .load_valid0, .load_valid1, .valid_set0, .valid_set1,
        .load_dirty0, .load_dirty1, .dirty_set0, .dirty_set1,
        .wdata_sel, .addr_sel,
        .hit0, .hit1, .dirty0, .dirty1, .lru,
        .mem_rdata, .pmem_address, .pmem_wdata
    );

endmodule : l2_cache

// File: l2_cache_assert.sv
`timescale 1ns/10ps

module l2_cache_assert (
    input logic clk,
    input logic arst_n,
    input logic mem_read,
    input logic mem_write,
    input logic mem_resp,
    input logic pmem_read,
    input logic pmem_write,
    input logic pmem_resp
);

    // One memory request at a time.
    one_pmem_request: assert property (@(posedge clk) disable iff (!arst_n)
        !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write are high together");

    pmem_read_held: assert property (@(posedge clk) disable iff (!arst_n)
        pmem_read && !pmem_resp |=> pmem_read)
        else $error("pmem_read dropped before pmem_resp");

    pmem_write_held: assert property (@(posedge clk) disable iff (!arst_n)
        pmem_write && !pmem_resp |=> pmem_write)
        else $error("pmem_write dropped before pmem_resp");

    // A response only answers a request that is present.
    resp_needs_request: assert property (@(posedge clk) disable iff (!arst_n)
        mem_resp |-> (mem_read || mem_write))
        else $error("mem_resp high without a request");

endmodule : l2_cache_assert

bind l2_cache l2_cache_assert l2_cache_assert_i (.*);

// File: l2_cache_tb.sv
`timescale 1ns/10ps

module l2_cache_tb;
    import l2_cache_geom_pkg::*;
    import l2_mem_pkg::*;

    localparam int NUM_OPS        = 16;
    localparam int MEM_SIZE       = 2 ** LINE_ADDR_W;
    localparam int SETS           = 2 ** INDEX_W;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 12 + 3 + 4;  // Ops, reset and idle cycles.

    logic       clk;
    logic       arst_n;
    logic       mem_read;
    logic       mem_write;
    addr_t      mem_address;
    line_t      mem_wdata;
    logic       mem_resp;
    line_t      mem_rdata;
    logic       pmem_resp;
    line_t      pmem_rdata;
    logic       pmem_read;
    logic       pmem_write;
    line_addr_t pmem_address;
    line_t      pmem_wdata;

    line_t      mem [MEM_SIZE];      // Memory model contents.
    line_t      ref_mem [MEM_SIZE];  // Data a read must return.
    int         rd_count;
    int         wr_count;
    line_addr_t last_rd_addr;
    line_addr_t last_wr_addr;
    line_t      last_wr_data;

    // Mirror of the tag, valid, dirty and LRU state.
    tag_t       m_tag [2][SETS];
    logic       m_valid [2][SETS];
    logic       m_dirty [2][SETS];
    logic       m_lru [SETS];

    logic       op_write [NUM_OPS];
    addr_t      op_addr [NUM_OPS];
    line_t      op_wdata [NUM_OPS];

    int         errors;
    int         checks;

    l2_cache l2_cache_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the request sequence did not finish in %0d cycles", TIMEOUT_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    function automatic line_t mem_pattern(line_addr_t la);
        logic [15:0] mix;
        mix = 16'(la) * 16'h9e37;
        return {8'h5a, 3'b000, la, 8'hc3, 3'b111, ~la, mix};
    endfunction

    function automatic addr_t addr_of(tag_t tag, index_t idx);
        return {tag, idx, {OFFSET_W{1'b0}}};
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %s is %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic set_op(int n, logic wr, addr_t addr, line_t data);
        op_write[n] = wr;
        op_addr[n]  = addr;
        op_wdata[n] = data;
    endtask

    task automatic load_table();
        set_op(0,  1'b0, addr_of(10'h001, 3'd2), '0);  // Cold miss.
        set_op(1,  1'b0, addr_of(10'h001, 3'd2), '0);
        set_op(2,  1'b1, addr_of(10'h001, 3'd2), 64'h1111_2222_3333_4444);
        set_op(3,  1'b0, addr_of(10'h001, 3'd2), '0);
        set_op(4,  1'b0, addr_of(10'h102, 3'd2), '0);  // Second way of set 2.
        set_op(5,  1'b0, addr_of(10'h001, 3'd2), '0);
        set_op(6,  1'b0, addr_of(10'h203, 3'd2), '0);  // Evicts a clean line.
        set_op(7,  1'b0, addr_of(10'h001, 3'd2), '0);
        set_op(8,  1'b0, addr_of(10'h102, 3'd2), '0);
        set_op(9,  1'b0, addr_of(10'h3f4, 3'd2), '0);  // Evicts the dirty line.
        set_op(10, 1'b0, addr_of(10'h001, 3'd2), '0);
        set_op(11, 1'b1, addr_of(10'h155, 3'd5), 64'hdead_beef_0123_4567);
        set_op(12, 1'b1, addr_of(10'h2aa, 3'd5), 64'hcafe_f00d_89ab_cdef);
        set_op(13, 1'b0, addr_of(10'h0f7, 3'd5), '0);
        set_op(14, 1'b0, addr_of(10'h155, 3'd5), '0);
        set_op(15, 1'b0, addr_of(10'h2aa, 3'd5), '0);
    endtask

    task automatic serve_memory();
        int unsigned delay;
        delay = $urandom_range(4, 1);
        repeat (delay - 1) begin
            @(posedge clk);
            #1;
        end
        if (pmem_read) begin
            pmem_rdata   = mem[pmem_address];
            last_rd_addr = pmem_address;
            rd_count++;
        end else begin
            mem[pmem_address] = pmem_wdata;
            last_wr_addr      = pmem_address;
            last_wr_data      = pmem_wdata;
            wr_count++;
        end
        pmem_resp = 1'b1;
        @(posedge clk);
        #1;
        pmem_resp = 1'b0;
    endtask

    // The response delays are drawn in this process.
    initial begin
        void'($urandom(32'he15bc035));
        forever begin
            @(posedge clk);
            #1;
            if (arst_n && (pmem_read || pmem_write)) serve_memory();
        end
    end

    // LRU names the way to evict; every access points it at the other way.
    task automatic predict(input logic wr, input addr_t addr, output int exp_rd,
                           output int exp_wr, output line_addr_t victim);
        index_t idx;
        tag_t   tag;
        int     way;
        idx    = addr[OFFSET_W +: INDEX_W];
        tag    = addr[ADDR_W-1 -: TAG_W];
        exp_rd = 0;
        exp_wr = 0;
        victim = '0;
        if (m_valid[0][idx] && m_tag[0][idx] == tag) begin
            way = 0;
        end else if (m_valid[1][idx] && m_tag[1][idx] == tag) begin
            way = 1;
        end else begin
            way    = m_lru[idx];
            exp_rd = 1;
            if (m_valid[way][idx] && m_dirty[way][idx]) begin
                exp_wr = 1;
                victim = {m_tag[way][idx], idx};
            end
            m_tag[way][idx]   = tag;
            m_valid[way][idx] = 1'b1;
            m_dirty[way][idx] = 1'b0;
        end
        m_lru[idx] = (way == 0);
        if (wr) m_dirty[way][idx] = 1'b1;
    endtask

    task automatic do_access(int n);
        int         rd_before;
        int         wr_before;
        int         exp_rd;
        int         exp_wr;
        line_addr_t line;
        line_addr_t victim;
        rd_before = rd_count;
        wr_before = wr_count;
        line      = op_addr[n][ADDR_W-1:OFFSET_W];
        predict(op_write[n], op_addr[n], exp_rd, exp_wr, victim);
        mem_read    = !op_write[n];
        mem_write   = op_write[n];
        mem_address = op_addr[n];
        mem_wdata   = op_wdata[n];
        @(negedge clk);
        while (!mem_resp) @(negedge clk);
        if (!op_write[n]) check_value("mem_rdata", mem_rdata, ref_mem[line]);
        check_value("pmem_read count", rd_count - rd_before, exp_rd);
        check_value("pmem_write count", wr_count - wr_before, exp_wr);
        if (exp_rd != 0) check_value("pmem_address of fetch", last_rd_addr, line);
        if (exp_wr != 0) begin
            check_value("pmem_address of write-back", last_wr_addr, victim);
            check_value("pmem_wdata", last_wr_data, ref_mem[victim]);
        end
        if (op_write[n]) ref_mem[line] = op_wdata[n];
        @(posedge clk);
        #1;
    endtask

    initial begin
        errors       = 0;
        checks       = 0;
        rd_count     = 0;
        wr_count     = 0;
        last_rd_addr = '0;
        last_wr_addr = '0;
        last_wr_data = '0;
        arst_n       = 1'b0;
        mem_read     = 1'b0;
        mem_write    = 1'b0;
        mem_address  = '0;
        mem_wdata    = '0;
        pmem_resp    = 1'b0;
        pmem_rdata   = '0;
        for (int a = 0; a < MEM_SIZE; a++) begin
            mem[a]     = mem_pattern(line_addr_t'(a));
            ref_mem[a] = mem[a];
        end
        for (int s = 0; s < SETS; s++) begin
            m_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                m_tag[w][s]   = '0;
                m_valid[w][s] = 1'b0;
                m_dirty[w][s] = 1'b0;
            end
        end
        load_table();
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (2) begin  // Idle after reset.
            @(negedge clk);
            check_value("mem_resp", mem_resp, 1'b0);
            check_value("pmem_read", pmem_read, 1'b0);
            check_value("pmem_write", pmem_write, 1'b0);
        end
        @(posedge clk);
        #1;
        for (int n = 0; n < NUM_OPS; n++) begin
            do_access(n);
        end
        $display("checks %0d, errors %0d, memory reads %0d, memory writes %0d",
                 checks, errors, rd_count, wr_count);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule : l2_cache_tb

// File: flist.f
l2_cache_geom_pkg.sv
l2_mem_pkg.sv
l2_cache_control.sv
l2_cache_datapath.sv
l2_cache.sv
l2_cache_assert.sv
l2_cache_tb.sv
